// File: rtl/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Cache geometry, sizes given as log2 of bytes
`define CACHE_SIZE_E 10
`define CLSIZE_E 5
`define CASSOC 2
`define VIRT_IDX_LEN 9

// Widths derived from the geometry
`define WAY_BITS ($clog2(`CASSOC))
`define SET_BITS (`VIRT_IDX_LEN - `CLSIZE_E)
`define LINE_BITS (`CACHE_SIZE_E - `CLSIZE_E)
`define TAG_LEN (32 - `VIRT_IDX_LEN)
// Word address inside the cache data array
`define CADDR_BITS (`CACHE_SIZE_E - 2)

// Ports and memory side
`define NUM_AGUS 2
`define AXI_NUM_TRANS 2
`define MEM_LATENCY 6

`endif

// File: rtl/cachePkg.sv
`include "cache_config.svh"

package cachePkg;

    typedef enum logic [2:0] {
        REGULAR,
        REGULAR_NO_EVICT,
        MGMT_CLEAN,
        MGMT_INVAL,
        MGMT_FLUSH,
        CONFLICT,
        TRANS_IN_PROG
    } MissType;

    typedef enum logic [1:0] {
        MEMC_NONE,
        MEMC_REPLACE,
        MEMC_CP_EXT_TO_CACHE,
        MEMC_CP_CACHE_TO_EXT
    } MemCmd;

    // Address bits above the index
    typedef struct packed {
        logic [`TAG_LEN-1:0] addr;
        logic valid;
    } CTEntry;

    typedef struct packed {
        logic valid;
        logic [`VIRT_IDX_LEN-1:0] addr;
    } CacheTableRead;

    typedef struct packed {
        CTEntry [`CASSOC-1:0] data;
    } CacheTableResult;

    typedef struct packed {
        CTEntry data;
        logic [`WAY_BITS-1:0] assoc;
        logic [`VIRT_IDX_LEN-1:0] addr;
        logic valid;
    } CacheTableWrite;

    // writeAddr carries the evicted tag in its upper bits
    typedef struct packed {
        logic valid;
        MissType mtype;
        logic [`WAY_BITS-1:0] assoc;
        logic [31:0] missAddr;
        logic [31:0] writeAddr;
    } CacheMiss;

    // Line index is {way, set}
    typedef struct packed {
        logic valid;
        logic [`LINE_BITS-1:0] idx;
    } CacheLineSetDirty;

    typedef struct packed {
        MemCmd cmd;
        logic [`CADDR_BITS-1:0] cacheAddr;
        logic [31:0] writeAddr;
        logic [31:0] readAddr;
    } MemControllerReq;

    typedef struct packed {
        logic valid;
        MemCmd cmd;
        logic [`CADDR_BITS-1:0] cacheAddr;
        logic [31:0] writeAddr;
        logic [31:0] readAddr;
    } MemTransfer;

    typedef struct packed {
        MemTransfer [`AXI_NUM_TRANS-1:0] transfers;
        logic stall;
    } MemControllerRes;

endpackage

// File: rtl/cacheTagTable.sv
`include "cache_config.svh"

module cacheTagTable
    import cachePkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  CacheTableWrite  write,

    input  CacheTableRead   read[`NUM_AGUS-1:0],
    output CacheTableResult result[`NUM_AGUS-1:0]
);

    localparam int NUM_SETS = 1 << `SET_BITS;

    // One row per set, holding every way
    CacheTableResult tags[NUM_SETS-1:0];

    logic [`SET_BITS-1:0] writeSet;

    assign writeSet = write.addr[`VIRT_IDX_LEN-1:`CLSIZE_E];

    always_ff @(posedge clk) begin
        if (write.valid && !rst) begin
            tags[writeSet].data[write.assoc] <= write.data;
        end
    end

    // Registered read per port, the row is held while no read is issued
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_AGUS; i++) begin
            if (rst) begin
                result[i] <= '0;
            end else if (read[i].valid) begin
                result[i] <= tags[read[i].addr[`VIRT_IDX_LEN-1:`CLSIZE_E]];
            end
        end
    end

endmodule

// File: rtl/cacheLineManager.sv
`include "cache_config.svh"

module cacheLineManager
    import cachePkg::*;
(
    input  logic             clk,
    input  logic             rst,

    input  logic             flush,
    input  logic             storeBusy,
    output logic             busy,

    input  CacheLineSetDirty setDirty,

    input  CacheTableRead    ctRead[`NUM_AGUS-1:0],
    output logic             ctReadReady[`NUM_AGUS-1:0],
    output CacheTableResult  ctResult[`NUM_AGUS-1:0],

    input  CacheMiss         miss,
    output logic             missReady,

    output CacheTableWrite   tableWrite,
    output CacheTableRead    tableRead[`NUM_AGUS-1:0],
    input  CacheTableResult  tableResult[`NUM_AGUS-1:0],

    output MemControllerReq  memReq,
    input  MemControllerRes  memRes
);

    localparam int NUM_LINES = 1 << `LINE_BITS;

    typedef enum logic [2:0] {
        IDLE,
        FLUSH_WAIT,
        FLUSH_READ0,
        FLUSH_READ1,
        FLUSH,
        FLUSH_FINALIZE
    } FlushState;

    FlushState state;

    logic [NUM_LINES-1:0] dirty;
    logic flushQueued;
    logic initialFlush;
    logic [`SET_BITS-1:0] flushIdx;
    logic [`WAY_BITS-1:0] flushWay;
    CTEntry flushEntry;

    logic [`SET_BITS-1:0] missSet;
    logic [`LINE_BITS-1:0] missIdx;
    logic [31-`CLSIZE_E:0] missLine;
    logic [31-`CLSIZE_E:0] evictLine;
    logic missDirty;
    logic missEvicts;
    MissType missKind;
    logic [`CADDR_BITS-1:0] missCacheAddr;
    logic [31:0] evictAddr;
    logic [31:0] loadAddr;

    MemTransfer pending;
    logic anyTransfer;
    logic canIssue;
    logic conflict;
    logic acceptMiss;

    CacheTableWrite prevWrite;
    CacheTableResult fwdData[`NUM_AGUS-1:0];
    logic [`CASSOC-1:0] fwdMask[`NUM_AGUS-1:0];

    function automatic logic hasWrite(input MemCmd cmd);
        return cmd == MEMC_REPLACE || cmd == MEMC_CP_CACHE_TO_EXT;
    endfunction

    function automatic logic hasRead(input MemCmd cmd);
        return cmd == MEMC_REPLACE || cmd == MEMC_CP_EXT_TO_CACHE;
    endfunction

    // Transfer touches the missed line location, its line or the evicted line
    function automatic logic clashes(input MemTransfer t);
        logic sameLoc;
        logic readAfterWrite;
        logic writeAfterRead;
        sameLoc = t.cacheAddr[`CADDR_BITS-1:`CLSIZE_E-2] == missIdx;
        readAfterWrite = hasWrite(t.cmd) && t.writeAddr[31:`CLSIZE_E] == missLine;
        writeAfterRead = missEvicts && hasRead(t.cmd) && t.readAddr[31:`CLSIZE_E] == evictLine;
        return t.valid && (sameLoc || readAfterWrite || writeAfterRead);
    endfunction

    assign missSet = miss.missAddr[`VIRT_IDX_LEN-1:`CLSIZE_E];
    assign missIdx = {miss.assoc, missSet};
    assign missLine = miss.missAddr[31:`CLSIZE_E];
    assign evictLine = {miss.writeAddr[31:`VIRT_IDX_LEN], missSet};
    assign missCacheAddr = {miss.assoc, miss.missAddr[`VIRT_IDX_LEN-1:2]};
    assign evictAddr = {miss.writeAddr[31:`VIRT_IDX_LEN], miss.missAddr[`VIRT_IDX_LEN-1:2], 2'b0};
    assign loadAddr = {miss.missAddr[31:2], 2'b0};

    // A store marking the line in this cycle counts too
    assign missDirty = dirty[missIdx] || (setDirty.valid && setDirty.idx == missIdx);

    always_comb begin
        missKind = miss.mtype;
        if (miss.mtype == REGULAR && !missDirty) begin
            missKind = REGULAR_NO_EVICT;
        end
    end

    assign missEvicts = missKind inside {REGULAR, MGMT_CLEAN, MGMT_FLUSH};

    assign pending = {memReq.cmd != MEMC_NONE, memReq};

    always_comb begin
        anyTransfer = 1'b0;
        conflict = miss.valid && clashes(pending);
        for (int i = 0; i < `AXI_NUM_TRANS; i++) begin
            anyTransfer = anyTransfer | memRes.transfers[i].valid;
            if (miss.valid && clashes(memRes.transfers[i])) begin
                conflict = 1'b1;
            end
        end
    end

    assign canIssue = memReq.cmd == MEMC_NONE || !memRes.stall;
    assign missReady = state == IDLE && canIssue && !conflict;
    assign acceptMiss = missReady && miss.valid &&
        miss.mtype != CONFLICT && miss.mtype != TRANS_IN_PROG;
    assign busy = flushQueued || state != IDLE;

    assign flushEntry = tableResult[0].data[flushWay];

    // New tag goes in as soon as the miss is taken
    always_comb begin
        tableWrite = '0;
        if (acceptMiss) begin
            tableWrite.assoc = miss.assoc;
            tableWrite.addr = miss.missAddr[`VIRT_IDX_LEN-1:0];
            case (miss.mtype)
                REGULAR, REGULAR_NO_EVICT: begin
                    tableWrite.valid = 1'b1;
                    tableWrite.data = '{addr: miss.missAddr[31:`VIRT_IDX_LEN], valid: 1'b1};
                end
                MGMT_INVAL, MGMT_FLUSH: begin
                    tableWrite.valid = 1'b1;
                end
                default: ;
            endcase
        end else if (state == FLUSH && canIssue) begin
            tableWrite.valid = 1'b1;
            tableWrite.assoc = flushWay;
            tableWrite.addr = {flushIdx, {`CLSIZE_E{1'b0}}};
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_AGUS; i++) begin
            tableRead[i] = ctRead[i];
            ctReadReady[i] = !tableWrite.valid;
        end
        // Port 0 belongs to the walk until the set is processed
        case (state)
            FLUSH_READ0: begin
                tableRead[0] = '{valid: 1'b1, addr: {flushIdx, {`CLSIZE_E{1'b0}}}};
                ctReadReady[0] = 1'b0;
            end
            FLUSH_READ1, FLUSH: begin
                tableRead[0].valid = 1'b0;
                ctReadReady[0] = 1'b0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        prevWrite <= tableWrite;
        if (rst) begin
            prevWrite.valid <= 1'b0;
        end
    end

    // Capture writes of this and the previous cycle for the read in flight
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_AGUS; i++) begin
            if (tableRead[i].valid) begin
                fwdMask[i] <= '0;
                if (prevWrite.valid && prevWrite.addr[`VIRT_IDX_LEN-1:`CLSIZE_E] ==
                        tableRead[i].addr[`VIRT_IDX_LEN-1:`CLSIZE_E]) begin
                    fwdMask[i][prevWrite.assoc] <= 1'b1;
                    fwdData[i].data[prevWrite.assoc] <= prevWrite.data;
                end
                // Newer write wins on the same way
                if (tableWrite.valid && tableWrite.addr[`VIRT_IDX_LEN-1:`CLSIZE_E] ==
                        tableRead[i].addr[`VIRT_IDX_LEN-1:`CLSIZE_E]) begin
                    fwdMask[i][tableWrite.assoc] <= 1'b1;
                    fwdData[i].data[tableWrite.assoc] <= tableWrite.data;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_AGUS; i++) begin
            ctResult[i] = tableResult[i];
            for (int w = 0; w < `CASSOC; w++) begin
                if (fwdMask[i][w]) begin
                    ctResult[i].data[w] = fwdData[i].data[w];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            flushQueued <= 1'b1;
            initialFlush <= 1'b1;
            dirty <= '0;
            memReq.cmd <= MEMC_NONE;
        end else begin
            if (canIssue) begin
                memReq.cmd <= MEMC_NONE;
            end
            if (flush) begin
                flushQueued <= 1'b1;
            end
            if (setDirty.valid) begin
                dirty[setDirty.idx] <= 1'b1;
            end

            case (state)
                IDLE: begin
                    if (acceptMiss) begin
                        dirty[missIdx] <= 1'b0;
                        case (missKind)
                            REGULAR:
                                memReq <= '{MEMC_REPLACE, missCacheAddr, evictAddr, loadAddr};
                            REGULAR_NO_EVICT:
                                memReq <= '{MEMC_CP_EXT_TO_CACHE, missCacheAddr, '0, loadAddr};
                            MGMT_CLEAN, MGMT_FLUSH:
                                memReq <= '{MEMC_CP_CACHE_TO_EXT, missCacheAddr, evictAddr, '0};
                            // Invalidation only touches the tag
                            default: ;
                        endcase
                    end
                    if (flushQueued) begin
                        state <= FLUSH_WAIT;
                        flushQueued <= 1'b0;
                        flushIdx <= '0;
                        flushWay <= '0;
                    end
                end

                FLUSH_WAIT: begin
                    if (!storeBusy && memReq.cmd == MEMC_NONE && !anyTransfer) begin
                        state <= FLUSH_READ0;
                    end
                end

                FLUSH_READ0: state <= FLUSH_READ1;

                FLUSH_READ1: state <= FLUSH;

                FLUSH: begin
                    if (canIssue) begin
                        // Nothing is written back on the walk after reset
                        if (flushEntry.valid && dirty[{flushWay, flushIdx}] && !initialFlush) begin
                            memReq <= '{
                                cmd:       MEMC_CP_CACHE_TO_EXT,
                                cacheAddr: {flushWay, flushIdx, {(`CLSIZE_E-2){1'b0}}},
                                writeAddr: {flushEntry.addr, flushIdx, {`CLSIZE_E{1'b0}}},
                                readAddr:  '0
                            };
                        end
                        dirty[{flushWay, flushIdx}] <= 1'b0;
                        flushWay <= flushWay + 1'b1;
                        if (&flushWay) begin
                            flushIdx <= flushIdx + 1'b1;
                            state <= (&flushIdx) ? FLUSH_FINALIZE : FLUSH_READ0;
                        end
                    end
                end

                FLUSH_FINALIZE: begin
                    if (memReq.cmd == MEMC_NONE && !anyTransfer) begin
                        state <= IDLE;
                        initialFlush <= 1'b0;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: rtl/memTransferTracker.sv
`include "cache_config.svh"

module memTransferTracker
    import cachePkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  MemControllerReq req,
    output MemControllerRes res,

    output MemTransfer      done
);

    localparam int CNT_BITS = $clog2(`MEM_LATENCY);

    MemTransfer slots[`AXI_NUM_TRANS-1:0];
    logic [CNT_BITS-1:0] remaining[`AXI_NUM_TRANS-1:0];

    logic freeFound;
    int freeSlot;
    logic accept;

    // Lowest free slot takes the next command
    always_comb begin
        freeFound = 1'b0;
        freeSlot = 0;
        for (int i = `AXI_NUM_TRANS - 1; i >= 0; i--) begin
            if (!slots[i].valid) begin
                freeFound = 1'b1;
                freeSlot = i;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `AXI_NUM_TRANS; i++) begin
            res.transfers[i] = slots[i];
        end
        res.stall = !freeFound;
    end

    assign accept = req.cmd != MEMC_NONE && freeFound;

    always_ff @(posedge clk) begin
        if (rst) begin
            done.valid <= 1'b0;
            for (int i = 0; i < `AXI_NUM_TRANS; i++) begin
                slots[i].valid <= 1'b0;
            end
        end else begin
            done.valid <= 1'b0;
            for (int i = 0; i < `AXI_NUM_TRANS; i++) begin
                if (slots[i].valid) begin
                    remaining[i] <= remaining[i] - 1'b1;
                    // Last cycle of the latency, report and free the slot
                    if (remaining[i] == CNT_BITS'(1)) begin
                        slots[i].valid <= 1'b0;
                        done <= slots[i];
                    end
                end
            end
            if (accept) begin
                slots[freeSlot] <= {1'b1, req};
                remaining[freeSlot] <= CNT_BITS'(`MEM_LATENCY - 1);
            end
        end
    end

endmodule

// File: rtl/dataCacheCtrl.sv
`include "cache_config.svh"

module dataCacheCtrl
    import cachePkg::*;
(
    input  logic             clk,
    input  logic             rst,

    input  logic             flush,
    input  logic             storeBusy,
    output logic             busy,

    input  CacheLineSetDirty setDirty,

    input  CacheTableRead    ctRead[`NUM_AGUS-1:0],
    output logic             ctReadReady[`NUM_AGUS-1:0],
    output CacheTableResult  ctResult[`NUM_AGUS-1:0],

    input  CacheMiss         miss,
    output logic             missReady,

    output MemTransfer       memDone
);

    CacheTableWrite tableWrite;
    CacheTableRead tableRead[`NUM_AGUS-1:0];
    CacheTableResult tableResult[`NUM_AGUS-1:0];
    MemControllerReq memReq;
    MemControllerRes memRes;

    cacheTagTable i_cacheTagTable (
        .clk    (clk),
        .rst    (rst),
        .write  (tableWrite),
        .read   (tableRead),
        .result (tableResult)
    );

    cacheLineManager i_cacheLineManager (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .storeBusy   (storeBusy),
        .busy        (busy),
        .setDirty    (setDirty),
        .ctRead      (ctRead),
        .ctReadReady (ctReadReady),
        .ctResult    (ctResult),
        .miss        (miss),
        .missReady   (missReady),
        .tableWrite  (tableWrite),
        .tableRead   (tableRead),
        .tableResult (tableResult),
        .memReq      (memReq),
        .memRes      (memRes)
    );

    // Latency model in place of the memory controller
    memTransferTracker i_memTransferTracker (
        .clk  (clk),
        .rst  (rst),
        .req  (memReq),
        .res  (memRes),
        .done (memDone)
    );

endmodule

// File: test/dataCacheCtrlTb.sv
`include "cache_config.svh"

module dataCacheCtrlTb
    import cachePkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SETS = 1 << `SET_BITS;
    localparam int NUM_ROWS = 17;
    localparam int TIMEOUT = 400;
    localparam int WAY_W = `WAY_BITS;
    localparam int SET_W = `SET_BITS;
    localparam int TAG_W = `TAG_LEN;
    localparam int WORD_W = `CLSIZE_E - 2;

    typedef enum logic [1:0] {
        OP_MISS,
        OP_DIRTY,
        OP_LOOKUP,
        OP_FLUSH
    } OpKind;

    // For lookups the way field picks the read port
    typedef struct packed {
        OpKind op;
        MissType mtype;
        logic [`WAY_BITS-1:0] way;
        logic [`SET_BITS-1:0] setIdx;
        logic [2:0] tagSel;
        MemCmd expCmd;
        logic blocked;
        logic waitDone;
    } StimRow;

    logic clk;
    logic rst;
    logic flush;
    logic storeBusy;
    logic busy;
    CacheLineSetDirty setDirty;
    CacheTableRead ctRead[`NUM_AGUS-1:0];
    logic ctReadReady[`NUM_AGUS-1:0];
    CacheTableResult ctResult[`NUM_AGUS-1:0];
    CacheMiss miss;
    logic missReady;
    MemTransfer memDone;

    // Reference model of the tag table and the dirty bits
    CTEntry modelTag[NUM_SETS][`CASSOC];
    logic modelDirty[NUM_SETS][`CASSOC];
    logic [`TAG_LEN-1:0] tagPool[8];
    StimRow rows[NUM_ROWS];
    MemTransfer expDone[$];
    MemTransfer gotDone[$];
    int doneCount;

    dataCacheCtrl i_dataCacheCtrl (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .storeBusy   (storeBusy),
        .busy        (busy),
        .setDirty    (setDirty),
        .ctRead      (ctRead),
        .ctReadReady (ctReadReady),
        .ctResult    (ctResult),
        .miss        (miss),
        .missReady   (missReady),
        .memDone     (memDone)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // A completion pulse lasts one cycle and is sampled once on the falling edge
    always @(negedge clk) begin
        if (!rst && memDone.valid) begin
            gotDone.push_back(memDone);
            doneCount++;
        end
    end

    task automatic reportMismatch(input string name, input logic [71:0] got,
            input logic [71:0] want);
        $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, want);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic reportFailure(input string what);
        $display("Error: %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fillTable();
        rows[0]  = '{OP_LOOKUP, REGULAR, 1'b0, 4'd0, 3'd0, MEMC_NONE, 1'b0, 1'b0};
        rows[1]  = '{OP_LOOKUP, REGULAR, 1'b1, 4'd9, 3'd0, MEMC_NONE, 1'b0, 1'b0};
        rows[2]  = '{OP_MISS, REGULAR, 1'b0, 4'd3, 3'd0, MEMC_CP_EXT_TO_CACHE, 1'b0, 1'b1};
        rows[3]  = '{OP_LOOKUP, REGULAR, 1'b0, 4'd3, 3'd0, MEMC_NONE, 1'b0, 1'b0};
        rows[4]  = '{OP_DIRTY, REGULAR, 1'b0, 4'd3, 3'd0, MEMC_NONE, 1'b0, 1'b0};
        rows[5]  = '{OP_MISS, REGULAR, 1'b0, 4'd3, 3'd1, MEMC_REPLACE, 1'b0, 1'b1};
        rows[6]  = '{OP_MISS, REGULAR, 1'b1, 4'd7, 3'd2, MEMC_CP_EXT_TO_CACHE, 1'b0, 1'b1};
        rows[7]  = '{OP_DIRTY, REGULAR, 1'b1, 4'd7, 3'd0, MEMC_NONE, 1'b0, 1'b0};
        rows[8]  = '{OP_MISS, MGMT_CLEAN, 1'b1, 4'd7, 3'd2, MEMC_CP_CACHE_TO_EXT, 1'b0, 1'b1};
        rows[9]  = '{OP_LOOKUP, REGULAR, 1'b1, 4'd7, 3'd0, MEMC_NONE, 1'b0, 1'b0};
        rows[10] = '{OP_MISS, REGULAR, 1'b0, 4'd12, 3'd3, MEMC_CP_EXT_TO_CACHE, 1'b0, 1'b1};
        rows[11] = '{OP_MISS, MGMT_INVAL, 1'b0, 4'd12, 3'd3, MEMC_NONE, 1'b0, 1'b1};
        // Second miss to the same location while the first transfer runs
        rows[12] = '{OP_MISS, REGULAR, 1'b1, 4'd3, 3'd4, MEMC_CP_EXT_TO_CACHE, 1'b0, 1'b0};
        rows[13] = '{OP_MISS, REGULAR, 1'b1, 4'd3, 3'd5, MEMC_CP_EXT_TO_CACHE, 1'b1, 1'b1};
        rows[14] = '{OP_DIRTY, REGULAR, 1'b0, 4'd3, 3'd0, MEMC_NONE, 1'b0, 1'b0};
        rows[15] = '{OP_DIRTY, REGULAR, 1'b1, 4'd7, 3'd0, MEMC_NONE, 1'b0, 1'b0};
        rows[16] = '{OP_FLUSH, REGULAR, 1'b0, 4'd0, 3'd0, MEMC_NONE, 1'b0, 1'b0};
    endtask

    // Starts at a falling edge and ends at one
    task automatic lookupSet(input int port, input logic [`SET_BITS-1:0] setIdx);
        int waited;
        CTEntry want;
        CTEntry got;
        ctRead[port] = '{valid: 1'b1, addr: {setIdx, {`CLSIZE_E{1'b0}}}};
        waited = 0;
        #1;
        while (!ctReadReady[port]) begin
            waited++;
            if (waited > TIMEOUT) begin
                reportFailure("timeout waiting for ctReadReady");
            end
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        ctRead[port].valid = 1'b0;
        for (int w = 0; w < `CASSOC; w++) begin
            want = modelTag[setIdx][w];
            got = ctResult[port].data[w];
            assert (got.valid == want.valid) else
                reportMismatch($sformatf("ctResult[%0d].data[%0d].valid", port, w),
                    72'(got.valid), 72'(want.valid));
            if (want.valid) begin
                assert (got.addr == want.addr) else
                    reportMismatch($sformatf("ctResult[%0d].data[%0d].addr", port, w),
                        72'(got.addr), 72'(want.addr));
            end
        end
    endtask

    task automatic markDirty(input logic [`WAY_BITS-1:0] way,
            input logic [`SET_BITS-1:0] setIdx);
        setDirty = '{valid: 1'b1, idx: {way, setIdx}};
        modelDirty[setIdx][way] = 1'b1;
        @(negedge clk);
        setDirty.valid = 1'b0;
    endtask

    task automatic issueMiss(input StimRow row);
        logic [31:0] lineAddr;
        CTEntry old;
        MemTransfer want;
        int waited;
        int donesBefore;
        bit sawLow;
        bit tagWrite;
        lineAddr = {tagPool[row.tagSel], row.setIdx, {`CLSIZE_E{1'b0}}};
        old = modelTag[row.setIdx][row.way];
        donesBefore = doneCount;
        miss = '{valid: 1'b1, mtype: row.mtype, assoc: row.way, missAddr: lineAddr,
            writeAddr: {old.addr, {`VIRT_IDX_LEN{1'b0}}}};
        waited = 0;
        sawLow = 1'b0;
        #1;
        while (!missReady) begin
            sawLow = 1'b1;
            waited++;
            if (waited > TIMEOUT) begin
                reportFailure("timeout waiting for missReady");
            end
            @(negedge clk);
            #1;
        end
        if (row.blocked) begin
            assert (sawLow) else
                reportFailure("missReady was high while the line's transfer was pending");
            assert (doneCount > donesBefore) else
                reportFailure("miss accepted before the pending transfer finished");
        end
        // A tag write in the acceptance cycle closes every read port
        tagWrite = row.mtype inside {REGULAR, REGULAR_NO_EVICT, MGMT_INVAL, MGMT_FLUSH};
        for (int p = 0; p < `NUM_AGUS; p++) begin
            assert (ctReadReady[p] == !tagWrite) else
                reportMismatch($sformatf("ctReadReady[%0d]", p), 72'(ctReadReady[p]),
                    72'(!tagWrite));
        end
        if (row.expCmd != MEMC_NONE) begin
            want = '0;
            want.valid = 1'b1;
            want.cmd = row.expCmd;
            want.cacheAddr = {row.way, row.setIdx, WORD_W'(0)};
            want.writeAddr = {old.addr, row.setIdx, {`CLSIZE_E{1'b0}}};
            want.readAddr = lineAddr;
            expDone.push_back(want);
        end
        // Loads and invalidations change the tag and a clean keeps it
        if (row.mtype inside {REGULAR, REGULAR_NO_EVICT}) begin
            modelTag[row.setIdx][row.way] = '{addr: tagPool[row.tagSel], valid: 1'b1};
        end else if (row.mtype inside {MGMT_INVAL, MGMT_FLUSH}) begin
            modelTag[row.setIdx][row.way] = '0;
        end
        modelDirty[row.setIdx][row.way] = 1'b0;
        @(negedge clk);
        miss = '0;
        lookupSet(1, row.setIdx);
    endtask

    task automatic compareTransfer(input MemTransfer got, input MemTransfer want);
        assert (got.cmd == want.cmd) else
            reportMismatch("memDone.cmd", 72'(got.cmd), 72'(want.cmd));
        assert (got.cacheAddr == want.cacheAddr) else
            reportMismatch("memDone.cacheAddr", 72'(got.cacheAddr), 72'(want.cacheAddr));
        if (want.cmd != MEMC_CP_EXT_TO_CACHE) begin
            assert (got.writeAddr == want.writeAddr) else
                reportMismatch("memDone.writeAddr", 72'(got.writeAddr), 72'(want.writeAddr));
        end
        if (want.cmd != MEMC_CP_CACHE_TO_EXT) begin
            assert (got.readAddr == want.readAddr) else
                reportMismatch("memDone.readAddr", 72'(got.readAddr), 72'(want.readAddr));
        end
    endtask

    // Completions of sequential misses arrive in order
    task automatic checkDones();
        int waited;
        #1;
        while (expDone.size() > 0) begin
            waited = 0;
            while (gotDone.size() == 0) begin
                waited++;
                if (waited > TIMEOUT) begin
                    reportFailure("timeout waiting for memDone");
                end
                @(negedge clk);
                #1;
            end
            compareTransfer(gotDone.pop_front(), expDone.pop_front());
        end
        @(negedge clk);
    endtask

    task automatic expectNoDone();
        repeat (`MEM_LATENCY + 4) @(negedge clk);
        #1;
        assert (gotDone.size() == 0) else
            reportFailure("memDone appeared for a request without a command");
        @(negedge clk);
    endtask

    task automatic waitNotBusy();
        int waited;
        waited = 0;
        while (busy) begin
            waited++;
            if (waited > TIMEOUT) begin
                reportFailure("timeout waiting for busy to fall");
            end
            @(negedge clk);
        end
    endtask

    task automatic runFlush();
        MemTransfer want[$];
        MemTransfer one;
        MemTransfer got;
        int hit;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < `CASSOC; w++) begin
                if (modelTag[s][w].valid && modelDirty[s][w]) begin
                    one = '0;
                    one.valid = 1'b1;
                    one.cmd = MEMC_CP_CACHE_TO_EXT;
                    one.cacheAddr = {WAY_W'(w), SET_W'(s), WORD_W'(0)};
                    one.writeAddr = {modelTag[s][w].addr, SET_W'(s), {`CLSIZE_E{1'b0}}};
                    want.push_back(one);
                end
            end
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        assert (busy) else
            reportMismatch("busy", 72'(busy), 72'(1));
        waitNotBusy();
        #1;
        assert (gotDone.size() == want.size()) else
            reportMismatch("write-back count", 72'(gotDone.size()), 72'(want.size()));
        while (gotDone.size() > 0) begin
            got = gotDone.pop_front();
            hit = -1;
            for (int i = 0; i < want.size(); i++) begin
                if (want[i].cacheAddr == got.cacheAddr) begin
                    hit = i;
                end
            end
            assert (hit >= 0) else
                reportFailure("flush wrote back a line that was not dirty");
            compareTransfer(got, want[hit]);
            want.delete(hit);
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < `CASSOC; w++) begin
                modelTag[s][w] = '0;
                modelDirty[s][w] = 1'b0;
            end
        end
        @(negedge clk);
        for (int s = 0; s < NUM_SETS; s++) begin
            lookupSet(s % `NUM_AGUS, SET_W'(s));
        end
    endtask

    initial begin
        void'($urandom(87));
        rst = 1'b1;
        flush = 1'b0;
        storeBusy = 1'b0;
        setDirty = '0;
        miss = '0;
        doneCount = 0;
        for (int p = 0; p < `NUM_AGUS; p++) begin
            ctRead[p] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            tagPool[i] = TAG_W'($urandom);
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < `CASSOC; w++) begin
                modelTag[s][w] = '0;
                modelDirty[s][w] = 1'b0;
            end
        end
        fillTable();

        repeat (16) @(negedge clk);
        rst = 1'b0;
        // Walk after reset invalidates everything and writes nothing back
        waitNotBusy();
        #1;
        assert (gotDone.size() == 0) else
            reportFailure("memDone appeared during the walk after reset");
        @(negedge clk);

        foreach (rows[r]) begin
            case (rows[r].op)
                OP_MISS: begin
                    issueMiss(rows[r]);
                    if (rows[r].waitDone) begin
                        if (rows[r].expCmd == MEMC_NONE) begin
                            expectNoDone();
                        end else begin
                            checkDones();
                        end
                    end
                end
                OP_DIRTY: markDirty(rows[r].way, rows[r].setIdx);
                OP_LOOKUP: lookupSet(rows[r].way, rows[r].setIdx);
                OP_FLUSH: runFlush();
                default: ;
            endcase
        end

        #1;
        assert (gotDone.size() == 0) else
            reportFailure("memDone appeared without a matching request");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: src.f
+incdir+rtl
rtl/cachePkg.sv
rtl/cacheTagTable.sv
rtl/cacheLineManager.sv
rtl/memTransferTracker.sv
rtl/dataCacheCtrl.sv
test/dataCacheCtrlTb.sv

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module dataCacheCtrlTb \
    --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
    exit 0
fi

echo "Pass line not found in sim.log"
exit 1
